//--- src/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath widths
`define XLEN        32
`define REG_ADDR_W  5

// instruction field positions
`define OP_FIELD      6:0
`define RD_FIELD      11:7
`define FUNCT3_FIELD  14:12
`define RS1_FIELD     19:15
`define RS2_FIELD     24:20
`define FUNCT7_FIELD  31:25

// first fetch address after reset
`define RESET_PC  32'h0000_0000

// data ram depth in words
`define DMEM_WORDS  256

// addi x0,x0,0 loaded into flushed stages
`define NOP_WORD  32'h0000_0013

`endif

//--- src/rv_pkg.sv
package rv_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

    // BR_ALWAYS covers jal and jalr
    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
    } br_cond_e;

endpackage

//--- src/control_unit.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module control_unit import rv_pkg::*; (
    input  logic [`XLEN-1:0]        instr,
    output alu_op_e                 alu_op,
    output br_cond_e                br_cond,
    output logic                    pc_rs1_sel,   // 1: operand one is the pc
    output logic                    imm_rs2_sel,  // 1: operand two is the immediate
    output logic                    mem_wr_en,
    output logic                    reg_wr_en,
    output wb_sel_e                 wb_sel,
    output logic                    jalr_sel,     // target from rs1 instead of pc
    output logic signed [`XLEN-1:0] imm
);
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       reg_wr;                           // before the rd == 0 mask
    logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign funct3 = instr[`FUNCT3_FIELD];
    assign funct7 = instr[`FUNCT7_FIELD];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3 to alu operation, alt picks sub / sra
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        alu_op      = ALU_ADD;                    // address add for loads, stores, auipc
        br_cond     = BR_NONE;
        pc_rs1_sel  = 1'b0;
        imm_rs2_sel = 1'b1;
        mem_wr_en   = 1'b0;
        reg_wr      = 1'b0;
        wb_sel      = WB_ALU;
        jalr_sel    = 1'b0;
        imm         = imm_i;
        case (opcode_e'(instr[`OP_FIELD]))
            OPC_LUI: begin
                alu_op = ALU_PASS_B;
                imm    = imm_u;
                reg_wr = 1'b1;
            end
            OPC_AUIPC: begin
                pc_rs1_sel = 1'b1;
                imm        = imm_u;
                reg_wr     = 1'b1;
            end
            OPC_JAL: begin
                br_cond = BR_ALWAYS;
                imm     = imm_j;
                reg_wr  = 1'b1;
                wb_sel  = WB_PC4;                 // link value
            end
            OPC_JALR: begin
                br_cond  = BR_ALWAYS;
                jalr_sel = 1'b1;
                reg_wr   = 1'b1;
                wb_sel   = WB_PC4;
            end
            OPC_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  br_cond = BR_EQ;
                    3'b001:  br_cond = BR_NE;
                    3'b100:  br_cond = BR_LT;
                    3'b101:  br_cond = BR_GE;
                    3'b110:  br_cond = BR_LTU;
                    3'b111:  br_cond = BR_GEU;
                    default: br_cond = BR_NONE;
                endcase
            end
            OPC_LOAD: begin
                reg_wr = 1'b1;
                wb_sel = WB_LOAD;
            end
            OPC_STORE: begin
                imm       = imm_s;
                mem_wr_en = 1'b1;
            end
            OPC_OP_IMM: begin
                // only srai uses funct7, addi has no subi
                alu_op = alu_decode(funct3, funct3 == 3'b101 && funct7[5]);
                reg_wr = 1'b1;
            end
            OPC_OP: begin
                alu_op      = alu_decode(funct3, funct7[5]);
                imm_rs2_sel = 1'b0;
                reg_wr      = 1'b1;
            end
            default: ;                            // unknown opcode acts as a bubble
        endcase
    end

    assign reg_wr_en = reg_wr && (instr[`RD_FIELD] != '0);  // x0 writes never retire

endmodule

//--- src/register_file.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module register_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`XLEN-1:0]       wr_data,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`XLEN-1:0]       rs1_data,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       rs2_data
);
    logic [`XLEN-1:0] regs [1:31];                // x0 not stored

    // zero for x0, bypass a same-cycle write, else the array
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (wr_en && wr_addr == addr)
            return wr_data;                       // write-through
        return regs[addr];
    endfunction

    // reads follow the array and the pending write as well as the address
    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != '0)
            regs[wr_addr] <= wr_data;
    end

    // writeback never targets x0 since decode drops rd zero writes
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> wr_addr != '0);

endmodule

//--- src/instruction_decode.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module instruction_decode import rv_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`XLEN-1:0]        if_instr,
    input  logic [`XLEN-1:0]        if_pc,
    input  logic                    wb_en,        // register write from writeback
    input  logic [`REG_ADDR_W-1:0]  wb_rd,
    input  logic [`XLEN-1:0]        wb_data,
    input  logic                    redirect,     // taken branch in execute
    output alu_op_e                 id_alu_op,
    output br_cond_e                id_br_cond,
    output logic [`XLEN-1:0]        id_in1,
    output logic [`XLEN-1:0]        id_in2,
    output logic signed [`XLEN-1:0] id_imm,
    output logic [`XLEN-1:0]        id_pc,
    output logic                    id_jalr_sel,
    output logic                    id_mem_wr_en,
    output logic [`XLEN-1:0]        id_rs2_data,
    output logic                    id_reg_wr_en,
    output wb_sel_e                 id_wb_sel,
    output logic [`REG_ADDR_W-1:0]  id_rd
);
    alu_op_e                 alu_op;
    br_cond_e                br_cond;
    wb_sel_e                 wb_sel;
    logic                    pc_rs1_sel, imm_rs2_sel;
    logic                    mem_wr_en, reg_wr_en, jalr_sel;
    logic signed [`XLEN-1:0] imm;
    logic [`XLEN-1:0]        rs1_data, rs2_data;
    logic [`XLEN-1:0]        in1, in2;

    control_unit u_ctrl (
        .instr       (if_instr),
        .alu_op      (alu_op),
        .br_cond     (br_cond),
        .pc_rs1_sel  (pc_rs1_sel),
        .imm_rs2_sel (imm_rs2_sel),
        .mem_wr_en   (mem_wr_en),
        .reg_wr_en   (reg_wr_en),
        .wb_sel      (wb_sel),
        .jalr_sel    (jalr_sel),
        .imm         (imm)
    );

    register_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wb_en),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data),
        .rs1_addr (if_instr[`RS1_FIELD]),
        .rs1_data (rs1_data),
        .rs2_addr (if_instr[`RS2_FIELD]),
        .rs2_data (rs2_data)
    );

    // alu operand muxes
    assign in1 = pc_rs1_sel  ? if_pc : rs1_data;
    assign in2 = imm_rs2_sel ? imm   : rs2_data;

    // id/ex controls, a redirect squashes the wrong-path instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_br_cond   <= BR_NONE;
            id_mem_wr_en <= 1'b0;
            id_reg_wr_en <= 1'b0;
        end else if (redirect) begin
            id_br_cond   <= BR_NONE;
            id_mem_wr_en <= 1'b0;
            id_reg_wr_en <= 1'b0;
        end else begin
            id_br_cond   <= br_cond;
            id_mem_wr_en <= mem_wr_en;
            id_reg_wr_en <= reg_wr_en;
        end
    end

    // id/ex payload, meaningless once the enables are low
    always_ff @(posedge clk) begin
        id_alu_op   <= alu_op;
        id_in1      <= in1;
        id_in2      <= in2;
        id_imm      <= imm;
        id_pc       <= if_pc;
        id_jalr_sel <= jalr_sel;
        id_rs2_data <= rs2_data;
        id_wb_sel   <= wb_sel;
        id_rd       <= if_instr[`RD_FIELD];
    end

    // fetch must only hand over supported opcodes
    a_known_opcode: assert property (@(posedge clk) disable iff (!rst_n)
        if_instr[`OP_FIELD] inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                                    OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP});

endmodule

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module fetch_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [`XLEN-1:0] imem_data,    // word at imem_addr, valid by the rising edge
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirect_pc,
    output logic [`XLEN-1:0] imem_addr,
    output logic [`XLEN-1:0] if_instr,
    output logic [`XLEN-1:0] if_pc
);
    logic [`XLEN-1:0] pc;

    assign imem_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= `RESET_PC;
            if_instr <= `NOP_WORD;                // pipeline starts full of bubbles
            if_pc    <= `RESET_PC;
        end else begin
            pc       <= redirect ? redirect_pc : pc + `XLEN'd4;
            if_instr <= redirect ? `NOP_WORD : imem_data;  // drop the wrong-path word
            if_pc    <= pc;
        end
    end

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module execute_stage import rv_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  alu_op_e                 id_alu_op,
    input  br_cond_e                id_br_cond,
    input  logic [`XLEN-1:0]        id_in1,
    input  logic [`XLEN-1:0]        id_in2,
    input  logic signed [`XLEN-1:0] id_imm,
    input  logic [`XLEN-1:0]        id_pc,
    input  logic                    id_jalr_sel,
    input  logic                    id_mem_wr_en,
    input  logic [`XLEN-1:0]        id_rs2_data,
    input  logic                    id_reg_wr_en,
    input  wb_sel_e                 id_wb_sel,
    input  logic [`REG_ADDR_W-1:0]  id_rd,
    output logic                    redirect,
    output logic [`XLEN-1:0]        redirect_pc,
    output logic [`XLEN-1:0]        ex_result,
    output logic [`XLEN-1:0]        ex_pc_4,
    output logic [`XLEN-1:0]        ex_pc,
    output logic [`XLEN-1:0]        ex_store_data,
    output logic                    ex_mem_wr_en,
    output logic                    ex_reg_wr_en,
    output wb_sel_e                 ex_wb_sel,
    output logic [`REG_ADDR_W-1:0]  ex_rd
);
    logic [`XLEN-1:0] result;
    logic [4:0]       shamt;
    logic             taken;
    logic [`XLEN-1:0] jalr_target;

    assign shamt = id_in2[4:0];

    always_comb begin
        case (id_alu_op)
            ALU_ADD:  result = id_in1 + id_in2;
            ALU_SUB:  result = id_in1 - id_in2;
            ALU_SLL:  result = id_in1 << shamt;
            ALU_SLT:  result = {31'b0, $signed(id_in1) < $signed(id_in2)};
            ALU_SLTU: result = {31'b0, id_in1 < id_in2};
            ALU_XOR:  result = id_in1 ^ id_in2;
            ALU_SRL:  result = id_in1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(id_in1) >>> shamt);
            ALU_OR:   result = id_in1 | id_in2;
            ALU_AND:  result = id_in1 & id_in2;
            default:  result = id_in2;            // pass-b for lui
        endcase
    end

    // branches compare rs1 (in1) with rs2, in2 may hold the offset
    always_comb begin
        case (id_br_cond)
            BR_EQ:     taken = id_in1 == id_rs2_data;
            BR_NE:     taken = id_in1 != id_rs2_data;
            BR_LT:     taken = $signed(id_in1) <  $signed(id_rs2_data);
            BR_GE:     taken = $signed(id_in1) >= $signed(id_rs2_data);
            BR_LTU:    taken = id_in1 <  id_rs2_data;
            BR_GEU:    taken = id_in1 >= id_rs2_data;
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign jalr_target = id_in1 + id_imm;
    assign redirect    = taken;
    assign redirect_pc = id_jalr_sel ? {jalr_target[`XLEN-1:1], 1'b0} : id_pc + id_imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_wr_en <= 1'b0;
            ex_reg_wr_en <= 1'b0;
        end else begin
            ex_mem_wr_en <= id_mem_wr_en;
            ex_reg_wr_en <= id_reg_wr_en;
        end
    end

    always_ff @(posedge clk) begin
        ex_result     <= result;
        ex_pc_4       <= id_pc + `XLEN'd4;        // link value for jal / jalr
        ex_pc         <= id_pc;
        ex_store_data <= id_rs2_data;
        ex_wb_sel     <= id_wb_sel;
        ex_rd         <= id_rd;
    end

    // a misaligned target would fetch garbage next cycle
    a_target_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> redirect_pc[1:0] == 2'b00);

endmodule

//--- src/mem_wb_stage.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module mem_wb_stage import rv_pkg::*; #(
    parameter int DMEM_DEPTH = `DMEM_WORDS
) (
    input  logic                   clk,
    input  logic [`XLEN-1:0]       ex_result,      // alu result or memory address
    input  logic [`XLEN-1:0]       ex_pc_4,
    input  logic [`XLEN-1:0]       ex_pc,
    input  logic [`XLEN-1:0]       ex_store_data,
    input  logic                   ex_mem_wr_en,
    input  logic                   ex_reg_wr_en,
    input  wb_sel_e                ex_wb_sel,
    input  logic [`REG_ADDR_W-1:0] ex_rd,
    output logic                   wb_en,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data,
    output logic [`XLEN-1:0]       wb_pc
);
    localparam int AW = $clog2(DMEM_DEPTH);

    logic [`XLEN-1:0] dmem [DMEM_DEPTH];
    logic [AW-1:0]    word_addr;
    logic [`XLEN-1:0] load_word;

    assign word_addr = ex_result[AW+1:2];         // word aligned, upper bits wrap
    assign load_word = dmem[word_addr];           // asynchronous read

    always_ff @(posedge clk) begin
        if (ex_mem_wr_en)
            dmem[word_addr] <= ex_store_data;
    end

    always_comb begin
        case (ex_wb_sel)
            WB_LOAD: wb_data = load_word;
            WB_PC4:  wb_data = ex_pc_4;
            default: wb_data = ex_result;
        endcase
    end

    // retire port doubles as the register write
    assign wb_en = ex_reg_wr_en;
    assign wb_rd = ex_rd;
    assign wb_pc = ex_pc;

endmodule

//--- src/rv_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core import rv_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    output logic [`XLEN-1:0]       imem_addr,
    input  logic [`XLEN-1:0]       imem_data,
    output logic                   wb_en,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data,
    output logic [`XLEN-1:0]       wb_pc
);
    logic                    redirect;
    logic [`XLEN-1:0]        redirect_pc;
    logic [`XLEN-1:0]        if_instr, if_pc;
    alu_op_e                 id_alu_op;
    br_cond_e                id_br_cond;
    logic [`XLEN-1:0]        id_in1, id_in2, id_pc, id_rs2_data;
    logic signed [`XLEN-1:0] id_imm;
    logic                    id_jalr_sel, id_mem_wr_en, id_reg_wr_en;
    wb_sel_e                 id_wb_sel, ex_wb_sel;
    logic [`REG_ADDR_W-1:0]  id_rd, ex_rd;
    logic [`XLEN-1:0]        ex_result, ex_pc_4, ex_pc, ex_store_data;
    logic                    ex_mem_wr_en, ex_reg_wr_en;

    fetch_stage u_fetch (
        .clk(clk), .rst_n(rst_n), .imem_data(imem_data), .redirect(redirect),
        .redirect_pc(redirect_pc), .imem_addr(imem_addr), .if_instr(if_instr), .if_pc(if_pc)
    );

    instruction_decode u_decode (
        .clk(clk), .rst_n(rst_n), .if_instr(if_instr), .if_pc(if_pc),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data), .redirect(redirect),
        .id_alu_op(id_alu_op), .id_br_cond(id_br_cond), .id_in1(id_in1), .id_in2(id_in2),
        .id_imm(id_imm), .id_pc(id_pc), .id_jalr_sel(id_jalr_sel),
        .id_mem_wr_en(id_mem_wr_en), .id_rs2_data(id_rs2_data),
        .id_reg_wr_en(id_reg_wr_en), .id_wb_sel(id_wb_sel), .id_rd(id_rd)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n), .id_alu_op(id_alu_op), .id_br_cond(id_br_cond),
        .id_in1(id_in1), .id_in2(id_in2), .id_imm(id_imm), .id_pc(id_pc),
        .id_jalr_sel(id_jalr_sel), .id_mem_wr_en(id_mem_wr_en), .id_rs2_data(id_rs2_data),
        .id_reg_wr_en(id_reg_wr_en), .id_wb_sel(id_wb_sel), .id_rd(id_rd),
        .redirect(redirect), .redirect_pc(redirect_pc), .ex_result(ex_result),
        .ex_pc_4(ex_pc_4), .ex_pc(ex_pc), .ex_store_data(ex_store_data),
        .ex_mem_wr_en(ex_mem_wr_en), .ex_reg_wr_en(ex_reg_wr_en),
        .ex_wb_sel(ex_wb_sel), .ex_rd(ex_rd)
    );

    mem_wb_stage u_mem_wb (
        .clk(clk), .ex_result(ex_result), .ex_pc_4(ex_pc_4), .ex_pc(ex_pc),
        .ex_store_data(ex_store_data), .ex_mem_wr_en(ex_mem_wr_en),
        .ex_reg_wr_en(ex_reg_wr_en), .ex_wb_sel(ex_wb_sel), .ex_rd(ex_rd),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data), .wb_pc(wb_pc)
    );

endmodule

//--- bench/core_checker.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module core_checker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_en,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data,
    input  logic [`XLEN-1:0]       wb_pc
);
    // expected retire records, in retire order
    logic [`XLEN-1:0]       exp_pc[$];
    logic [`REG_ADDR_W-1:0] exp_rd[$];
    logic [`XLEN-1:0]       exp_data[$];
    int                     rec_test[$];          // owning test of each record

    string test_name[$];
    int    test_left[$];                          // records still to come
    bit    test_bad[$];

    int pass_n = 0;
    int fail_n = 0;
    int stray_n = 0;                              // retires nobody expected

    task automatic add_test(input string name, input int count);
        test_name.push_back(name);
        test_left.push_back(count);
        test_bad.push_back(1'b0);
    endtask

    // belongs to the most recently added test
    task automatic add_record(input logic [`XLEN-1:0] pc, input logic [`REG_ADDR_W-1:0] rd,
                              input logic [`XLEN-1:0] data);
        exp_pc.push_back(pc);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        rec_test.push_back(test_name.size() - 1);
    endtask

    function automatic bit mismatch(input string sig, input logic [`XLEN-1:0] expected,
                                    input logic [`XLEN-1:0] got);
        if (got !== expected) begin
            $display("CHECK FAILED %0t %s expected %h got %h", $time, sig, expected, got);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic check_retire();
        int t;
        bit bad;
        if (exp_pc.size() == 0) begin
            $display("%0t: pc %h retired into x%0d after all expected records were used",
                     $time, wb_pc, wb_rd);
            stray_n++;
        end else begin
            t   = rec_test.pop_front();
            bad = mismatch("wb_pc", exp_pc.pop_front(), wb_pc);
            bad = mismatch("wb_rd", {27'b0, exp_rd.pop_front()}, {27'b0, wb_rd}) | bad;
            bad = mismatch("wb_data", exp_data.pop_front(), wb_data) | bad;
            if (bad)
                test_bad[t] = 1'b1;
            test_left[t] = test_left[t] - 1;
            if (test_left[t] == 0) begin               // last record of this test
                $display("test %-8s %s", test_name[t], test_bad[t] ? "failed" : "ok");
                if (test_bad[t])
                    fail_n++;
                else
                    pass_n++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && wb_en)
            check_retire();
    end

    // called once the pipeline has drained
    task automatic wrap_up(output int passed, output int failed);
        for (int i = 0; i < test_name.size(); i++) begin
            if (test_left[i] > 0) begin
                $display("test %-8s failed, %0d expected retires never happened",
                         test_name[i], test_left[i]);
                fail_n++;
            end
        end
        $display("tests passed %0d, failed %0d, unexpected retires %0d",
                 pass_n, fail_n, stray_n);
        passed = pass_n;
        failed = fail_n + stray_n;
    endtask

endmodule

//--- bench/tb_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_core;
    logic                   clk;
    logic                   rst_n;
    logic [`XLEN-1:0]       imem_addr;
    logic [`XLEN-1:0]       imem_data;
    logic                   wb_en;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;
    logic [`XLEN-1:0]       wb_pc;

    logic [`XLEN-1:0] imem [0:255];               // 1 KiB program space
    int               prog_words = 0;             // highest loaded word plus one
    bit               loaded = 1'b0;

    rv_core dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .wb_pc     (wb_pc)
    );

    core_checker chk0 (
        .clk(clk), .rst_n(rst_n), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data), .wb_pc(wb_pc)
    );

    always #4 clk = ~clk;                         // 8 ns period

    // nop outside the loaded range lets the pipeline drain
    function automatic logic [`XLEN-1:0] fetch_word(input logic [`XLEN-1:0] addr);
        if (addr[31:10] != 22'b0)
            return `NOP_WORD;
        return imem[addr[9:2]];
    endfunction

    always @(negedge clk)
        imem_data <= fetch_word(imem_addr);

    // fills imem and hands test records to the checker
    task automatic load_stimulus(output bit ok);
        int                     fd;
        int                     code;
        int                     cnt;
        string                  tag;
        string                  name;
        string                  rest;
        logic [`XLEN-1:0]       a, w, d;
        logic [`REG_ADDR_W-1:0] rd;
        ok = 1'b1;
        fd = $fopen("bench/core_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/core_stimulus.txt");
            ok = 1'b0;
        end else begin
            while (ok && !$feof(fd)) begin
                code = $fscanf(fd, "%s", tag);
                if (code != 1)
                    break;
                if (tag == "I") begin
                    code = $fscanf(fd, "%h %h", a, w);
                    imem[a[9:2]] = w;
                    if (int'(a[31:2]) + 1 > prog_words)
                        prog_words = int'(a[31:2]) + 1;
                end else if (tag == "T") begin
                    code = $fscanf(fd, "%s %d", name, cnt);
                    chk0.add_test(name, cnt);
                end else if (tag == "E") begin
                    code = $fscanf(fd, "%h %d %h", a, rd, d);
                    chk0.add_record(a, rd, d);
                end else if (tag == "#") begin
                    code = $fgets(rest, fd);           // comment line
                end else begin
                    $display("stimulus file has an unknown line type '%s'", tag);
                    ok = 1'b0;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        bit ok;
        int passed;
        int failed;
        clk       = 1'b0;
        rst_n     = 1'b0;
        imem_data = `NOP_WORD;
        for (int i = 0; i < 256; i++)
            imem[i] = `NOP_WORD;                  // unloaded words act as bubbles
        load_stimulus(ok);
        if (!ok) begin
            $display("stimulus could not be loaded, nothing was run");
            $display("** FAIL **");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (16) @(posedge clk);
            @(negedge clk) rst_n = 1'b1;
            wait (imem_addr >= 32'(prog_words) * 4);
            repeat (5) @(posedge clk);            // last word retires four edges later
            @(negedge clk);
            chk0.wrap_up(passed, failed);
            if (failed == 0 && passed > 0)
                $display("** PASS **");
            else
                $display("** FAIL **");
            $finish;
        end
    end

    // four cycles per word covers every pipeline fill and flush
    initial begin
        wait (loaded && rst_n);
        repeat (4 * prog_words + 100) @(posedge clk);
        $display("timeout, the program did not finish in %0d cycles", 4 * prog_words + 100);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- bench/core_stimulus.txt
# I <byte addr> <instr word>, T <test name> <record count>
# E <retire pc> <rd decimal> <rd value>, other numbers hex
I 00 FFB00093
I 04 00300113
I 10 40208233
I 14 0020A2B3
I 18 0020B333
I 1C 4020D3B3
I 20 0040D413
I 24 0F014493
I 28 00811513
I 2C 123451B7
I 30 00001597
# six branch pairs, not taken then taken over two wrong-path addi x12
I 34 00208663
I 38 00210663
I 3C 00100613
I 40 00200613
I 44 00211663
I 48 00209663
I 4C 00100613
I 50 00200613
I 54 00114663
I 58 0020C663
I 5C 00100613
I 60 00200613
I 64 0020D663
I 68 00115663
I 6C 00100613
I 70 00200613
I 74 0020E663
I 78 00116663
I 7C 00100613
I 80 00200613
I 84 00117663
I 88 0020F663
I 8C 00100613
I 90 00200613
I 94 00700693
# jal +12, then jalr 0x15(x14) lands on b0
I 98 00C0076F
I 9C 00100613
I A0 00200613
I A4 015707E7
I A8 00100613
I AC 00200613
I B0 00178813
I B4 04000893
I C0 0048A423
I CC 0088A903
I D0 00908013
I DC 002009B3
T arith 9
E 00 1 FFFFFFFB
E 04 2 00000003
E 10 4 FFFFFFF8
E 14 5 00000001
E 18 6 00000000
E 1C 7 FFFFFFFF
E 20 8 0FFFFFFF
E 24 9 000000F3
E 28 10 00000300
T upper 2
E 2C 3 12345000
E 30 11 00001030
T branch 1
E 94 13 00000007
T jump 3
E 98 14 0000009C
E A4 15 000000A8
E B0 16 000000A9
T memory 2
E B4 17 00000040
E CC 18 FFFFFFF8
T zero 1
E DC 19 00000003

//--- list.f
+incdir+src
src/rv_pkg.sv
src/control_unit.sv
src/register_file.sv
src/instruction_decode.sv
src/fetch_stage.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/rv_core.sv
bench/core_checker.sv
bench/tb_core.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_core -f list.f -o sim_core || exit 1
./obj_dir/sim_core > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
grep -q '\*\* PASS \*\*' sim.log || exit 1
exit 0
